// File: source/debug_dump_pkg.sv
package debug_dump_pkg;

  //////////////////////////////
  // Frame geometry
  //////////////////////////////

  localparam int DUMP_BYTES  = 132;                 // 32 registers x 4 bytes + 4 control bytes
  localparam int FRAME_BYTES = DUMP_BYTES + 1;      // Payload plus trailing checksum
  localparam int IDX_W       = $clog2(FRAME_BYTES); // Byte index width, 8 bits

  //////////////////////////////
  // Control byte tags
  //////////////////////////////

  // Each tag fills the unused upper bits of one control byte, so a host
  // parser can tell the four bytes apart
  localparam logic [1:0] TAG_ID2 = 2'b00;    // Byte 128, ID/EX 2-bit fields
  localparam logic [2:0] TAG_ID1 = 3'b101;   // Byte 129, ID/EX 1-bit flags
  localparam logic [2:0] TAG_EX  = 3'b010;   // Byte 130, EX/MEM bits
  localparam logic [4:0] TAG_MEM = 5'b00110; // Byte 131, MEM/WB bits

  //////////////////////////////
  // Controller states
  //////////////////////////////

  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0, // Waiting for a dump request
    ST_CAPTURE = 2'd1, // Freeze snapshot, clear checksum
    ST_SEND    = 2'd2, // Stream payload bytes
    ST_CHECK   = 2'd3  // Emit checksum byte
  } dump_state_t;

endpackage

// File: source/snapshot_buffer.sv
`timescale 1ns/100ps

module snapshot_buffer
  import debug_dump_pkg::*;
(
  input  logic             clk,
  input  logic             capture,         // Freeze inputs on this edge
  input  logic [1023:0]    reg_file,        // Register 0 in the low word
  // ID/EX latch
  input  logic             branch_id,
  input  logic             mem_read_id,
  input  logic             mem_write_id,
  input  logic             alu_src_id,
  input  logic             reg_write_id,
  input  logic [1:0]       reg_dst_id,
  input  logic [1:0]       mem_to_reg_id,
  input  logic [1:0]       alu_op_id,
  // EX/MEM latch
  input  logic             mem_read_ex,
  input  logic             mem_write_ex,
  input  logic             reg_write_ex,
  input  logic [1:0]       mem_to_reg_ex,
  // MEM/WB latch
  input  logic             reg_write_mem,
  input  logic [1:0]       mem_to_reg_mem,
  // Read side
  input  logic [IDX_W-1:0] rd_idx,          // Payload byte index
  output logic [7:0]       rd_byte          // Byte at rd_idx
);

  localparam int NUM_REGS  = 32;            // General registers
  localparam int REG_BYTES = 4 * NUM_REGS;  // Bytes 0..127

  logic [7:0] snap_mem [0:DUMP_BYTES-1];    // Frozen frame payload

  //////////////////////////////
  // Capture
  //////////////////////////////

  // Whole payload is written in one edge, so the copy is coherent
  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      for (int r = 0; r < NUM_REGS; r++)
      begin
        for (int b = 0; b < 4; b++)
        begin
          snap_mem[4*r + b] <= reg_file[32*r + 31 - 8*b -: 8]; // MSB first
        end
      end
      snap_mem[REG_BYTES + 0] <= {TAG_ID2, reg_dst_id, mem_to_reg_id, alu_op_id};
      snap_mem[REG_BYTES + 1] <= {TAG_ID1, branch_id, mem_read_id, mem_write_id,
                                  alu_src_id, reg_write_id};
      snap_mem[REG_BYTES + 2] <= {TAG_EX, mem_read_ex, mem_write_ex, reg_write_ex,
                                  mem_to_reg_ex};
      snap_mem[REG_BYTES + 3] <= {TAG_MEM, reg_write_mem, mem_to_reg_mem};
    end
  end

  //////////////////////////////
  // Read
  //////////////////////////////

  assign rd_byte = snap_mem[rd_idx]; // Combinational read, no latency

  // The controller owns rd_idx; it must never walk past the payload
  a_idx_in_range: assert property (@(posedge clk)
    !$isunknown(rd_idx) |-> (rd_idx < IDX_W'(DUMP_BYTES)));

endmodule

// File: source/byte_pacer.sv
`timescale 1ns/100ps

module byte_pacer #(
  parameter int PACE_CYCLES = 4             // Clocks per byte (at least 1)
) (
  input  logic clk,
  input  logic rst,
  input  logic pace_en,                     // Counter restarts while this is low
  output logic pace_tick                    // One-cycle pulse per byte slot
);

  localparam int CNT_W = $clog2(PACE_CYCLES + 1); // Holds PACE_CYCLES

  logic [CNT_W-1:0] cnt;                    // Cycles left to next tick

  if (PACE_CYCLES < 1)
  begin : g_bad_pace
    $error("byte_pacer: PACE_CYCLES must be at least 1");
  end

  // Preload to PACE_CYCLES so the first tick lands that many cycles
  // after enable; later reloads use PACE_CYCLES-1 since the tick cycle counts
  always_ff @(posedge clk)
  begin
    if (rst || !pace_en)
      cnt <= CNT_W'(PACE_CYCLES);           // Idle preload
    else if (cnt == '0)
      cnt <= CNT_W'(PACE_CYCLES - 1);       // Expired so start the next slot
    else
      cnt <= cnt - 1'b1;
  end

  assign pace_tick = pace_en && (cnt == '0);

  // The reload while disabled keeps the following cycle free of a tick
  a_idle_reload: assert property (@(posedge clk) disable iff (rst)
    !pace_en |=> !pace_tick);

  // First slot is exactly PACE_CYCLES long
  a_first_tick: assert property (@(posedge clk) disable iff (rst)
    $rose(pace_en) |-> (!pace_tick)[*PACE_CYCLES] ##1 pace_tick);

endmodule

// File: source/frame_checksum.sv
`timescale 1ns/100ps

module frame_checksum (
  input  logic       clk,
  input  logic       rst,
  input  logic       sum_clr,               // Frame start
  input  logic       sum_add,               // Fold data_in this cycle
  input  logic [7:0] data_in,               // Payload byte being emitted
  output logic [7:0] checksum               // XOR of bytes since last clear
);

  //////////////////////////////
  // Running XOR
  //////////////////////////////

  // Updated value is visible the cycle after sum_add
  always_ff @(posedge clk)
  begin
    if (rst || sum_clr)
      checksum <= 8'h00;
    else if (sum_add)
      checksum <= checksum ^ data_in;
  end

  // Clear and add never coincide: clear is in capture, adds in send
  a_no_clr_add: assert property (@(posedge clk) disable iff (rst)
    !(sum_clr && sum_add));

endmodule

// File: source/dump_ctrl.sv
`timescale 1ns/100ps

module dump_ctrl
  import debug_dump_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             dump_req,        // One-cycle request
  input  logic             pace_tick,       // Byte slot from pacer
  input  logic [7:0]       rd_byte,         // Payload byte at rd_idx
  input  logic [7:0]       checksum,        // Running XOR
  output logic             capture,         // Freeze snapshot
  output logic             pace_en,         // Pacer run level
  output logic [IDX_W-1:0] rd_idx,          // Next payload byte
  output logic             sum_clr,         // Clear checksum
  output logic             sum_add,         // Fold rd_byte into checksum
  output logic [7:0]       byte_data,       // Valid with byte_valid only
  output logic             byte_valid,      // Byte strobe
  output logic             busy,            // Frame in progress
  output logic             dump_done        // With checksum strobe
);

  dump_state_t state;
  dump_state_t state_next;
  logic        send_sum;                    // Select checksum over payload
  logic        emit;                        // Strobe due on this edge
  logic        last_byte;                   // rd_idx at final payload byte

  //////////////////////////////
  // Decode
  //////////////////////////////

  assign capture   = (state == ST_CAPTURE);
  assign sum_clr   = capture;               // New frame, new checksum
  assign pace_en   = (state != ST_IDLE);    // Rises with the capture cycle
  assign send_sum  = (state == ST_CHECK);
  assign sum_add   = pace_tick && (state == ST_SEND);
  assign emit      = sum_add || (pace_tick && send_sum);
  assign last_byte = (rd_idx == IDX_W'(DUMP_BYTES - 1));

  // busy still covers the done cycle, so a request there is dropped
  always_comb
  begin
    state_next = state;
    case (state)
      ST_IDLE:
        if (dump_req && !busy)
          state_next = ST_CAPTURE;
      ST_CAPTURE:
        state_next = ST_SEND;
      ST_SEND:
        if (pace_tick && last_byte)
          state_next = ST_CHECK;
      ST_CHECK:
        if (pace_tick)
          state_next = ST_IDLE;
      default:
        state_next = ST_IDLE;
    endcase
  end

  //////////////////////////////
  // Control registers
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= ST_IDLE;
      rd_idx     <= '0;
      byte_valid <= 1'b0;
      busy       <= 1'b0;
      dump_done  <= 1'b0;
    end
    else
    begin
      state      <= state_next;
      byte_valid <= emit;
      dump_done  <= emit && send_sum;       // Checksum strobe ends the frame
      if (capture)
        busy <= 1'b1;
      else if (dump_done)
        busy <= 1'b0;                       // Falls one edge after done
      if (capture)
        rd_idx <= '0;
      else if (sum_add)
        rd_idx <= last_byte ? '0 : rd_idx + IDX_W'(1); // Park at 0 for checksum
    end
  end

  // Output byte register
  always_ff @(posedge clk)
  begin
    if (emit)
      byte_data <= send_sum ? checksum : rd_byte;
  end

  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    dump_done |=> !dump_done);

  a_valid_busy: assert property (@(posedge clk) disable iff (rst)
    byte_valid |-> busy);

endmodule

// File: source/debug_dump_top.sv
`timescale 1ns/100ps

module debug_dump_top
  import debug_dump_pkg::*;
#(
  parameter int PACE_CYCLES = 4             // Clocks per output byte
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          dump_req,
  input  logic [1023:0] reg_file,
  input  logic          branch_id,
  input  logic          mem_read_id,
  input  logic          mem_write_id,
  input  logic          alu_src_id,
  input  logic          reg_write_id,
  input  logic [1:0]    reg_dst_id,
  input  logic [1:0]    mem_to_reg_id,
  input  logic [1:0]    alu_op_id,
  input  logic          mem_read_ex,
  input  logic          mem_write_ex,
  input  logic          reg_write_ex,
  input  logic [1:0]    mem_to_reg_ex,
  input  logic          reg_write_mem,
  input  logic [1:0]    mem_to_reg_mem,
  output logic [7:0]    byte_data,
  output logic          byte_valid,
  output logic          busy,
  output logic          dump_done
);

  logic             capture;
  logic             pace_en;
  logic             pace_tick;
  logic             sum_clr;
  logic             sum_add;
  logic [IDX_W-1:0] rd_idx;
  logic [7:0]       rd_byte;
  logic [7:0]       checksum;

  //////////////////////////////
  // Controller
  //////////////////////////////

  dump_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .dump_req   (dump_req),
    .pace_tick  (pace_tick),
    .rd_byte    (rd_byte),
    .checksum   (checksum),
    .capture    (capture),
    .pace_en    (pace_en),
    .rd_idx     (rd_idx),
    .sum_clr    (sum_clr),
    .sum_add    (sum_add),
    .byte_data  (byte_data),
    .byte_valid (byte_valid),
    .busy       (busy),
    .dump_done  (dump_done)
  );

  //////////////////////////////
  // Datapath
  //////////////////////////////

  snapshot_buffer u_buf (
    .clk            (clk),
    .capture        (capture),
    .reg_file       (reg_file),
    .branch_id      (branch_id),
    .mem_read_id    (mem_read_id),
    .mem_write_id   (mem_write_id),
    .alu_src_id     (alu_src_id),
    .reg_write_id   (reg_write_id),
    .reg_dst_id     (reg_dst_id),
    .mem_to_reg_id  (mem_to_reg_id),
    .alu_op_id      (alu_op_id),
    .mem_read_ex    (mem_read_ex),
    .mem_write_ex   (mem_write_ex),
    .reg_write_ex   (reg_write_ex),
    .mem_to_reg_ex  (mem_to_reg_ex),
    .reg_write_mem  (reg_write_mem),
    .mem_to_reg_mem (mem_to_reg_mem),
    .rd_idx         (rd_idx),
    .rd_byte        (rd_byte)
  );

  byte_pacer #(
    .PACE_CYCLES (PACE_CYCLES)
  ) u_pacer (
    .clk       (clk),
    .rst       (rst),
    .pace_en   (pace_en),
    .pace_tick (pace_tick)
  );

  frame_checksum u_sum (
    .clk      (clk),
    .rst      (rst),
    .sum_clr  (sum_clr),
    .sum_add  (sum_add),
    .data_in  (rd_byte),                    // Same byte that goes out
    .checksum (checksum)
  );

endmodule

// File: test/debug_dump_checker.sv
`timescale 1ns/100ps

module debug_dump_checker
  import debug_dump_pkg::*;
#(
  parameter int PACE_CYCLES = 4                 // Clocks per byte, same as the DUT
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          dump_req,
  input  logic [1023:0] reg_file,
  input  logic          branch_id, mem_read_id, mem_write_id, alu_src_id, reg_write_id,
  input  logic [1:0]    reg_dst_id, mem_to_reg_id, alu_op_id,
  input  logic          mem_read_ex, mem_write_ex, reg_write_ex,
  input  logic [1:0]    mem_to_reg_ex,
  input  logic          reg_write_mem,
  input  logic [1:0]    mem_to_reg_mem,
  input  logic [7:0]    byte_data,
  input  logic          byte_valid,
  input  logic          busy,
  input  logic          dump_done,
  output int            mismatch_cnt,           // Wrong values seen
  output int            other_cnt,              // Timing and protocol faults
  output int            frame_cnt,              // Frames closed by a checksum byte
  output int            strobe_cnt              // All byte strobes seen
);

  logic [7:0] exp_frame [0:FRAME_BYTES-1];      // Expected payload plus checksum
  logic       active;                           // Frame accepted, not yet closed
  logic       latch_due;                        // Snapshot edge comes next
  logic       busy_exp;                         // busy value expected at this edge
  int         cyc;                              // Edge counter since reset
  int         next_due;                         // Edge where the next strobe is sampled
  int         byte_idx;                         // Position within the frame

  // Expected frame from the reference layout
  task automatic build_frame();
    logic [31:0] word;
    logic [7:0]  sum;
    for (int r = 0; r < 32; r++)
    begin
      word = reg_file[32*r +: 32];
      exp_frame[4*r]     = word[31:24];         // Most significant byte first
      exp_frame[4*r + 1] = word[23:16];
      exp_frame[4*r + 2] = word[15:8];
      exp_frame[4*r + 3] = word[7:0];
    end
    exp_frame[128] = {2'b00, reg_dst_id, mem_to_reg_id, alu_op_id};
    exp_frame[129] = {3'b101, branch_id, mem_read_id, mem_write_id, alu_src_id, reg_write_id};
    exp_frame[130] = {3'b010, mem_read_ex, mem_write_ex, reg_write_ex, mem_to_reg_ex};
    exp_frame[131] = {5'b00110, reg_write_mem, mem_to_reg_mem};
    sum = 8'h00;
    for (int i = 0; i < DUMP_BYTES; i++)
      sum = sum ^ exp_frame[i];                 // XOR of the payload
    exp_frame[DUMP_BYTES] = sum;
  endtask

  //////////////////////////////
  // Monitor
  //////////////////////////////

  // DUT outputs are registered and inputs move 10 ns after the edge,
  // so values read here are the settled ones from the previous cycle
  always @(posedge clk)
  begin
    if (rst)
    begin
      active = 1'b0;
      latch_due = 1'b0;
      busy_exp = 1'b0;
      cyc = 0;
      mismatch_cnt = 0;
      other_cnt = 0;
      frame_cnt = 0;
      strobe_cnt = 0;
    end
    else
    begin
      cyc = cyc + 1;
      if (busy !== busy_exp)
      begin
        $display("Mismatch time=%0t signal=busy expected=%b actual=%b", $time, busy_exp, busy);
        mismatch_cnt++;
      end
      if (latch_due)
      begin
        build_frame();                          // Same edge the buffer captures on
        latch_due = 1'b0;
        busy_exp = 1'b1;
      end
      if (byte_valid)
      begin
        strobe_cnt++;
        if (!active)
        begin
          $display("Byte strobe outside any frame at %0t", $time);
          other_cnt++;
        end
        else
        begin
          if (cyc != next_due)
          begin
            $display("Byte %0d strobed at edge %0d, expected at edge %0d (time %0t)",
                     byte_idx, cyc, next_due, $time);
            other_cnt++;
          end
          if (byte_data !== exp_frame[byte_idx])
          begin
            $display("Mismatch time=%0t signal=byte_data[%0d] expected=%02h actual=%02h",
                     $time, byte_idx, exp_frame[byte_idx], byte_data);
            mismatch_cnt++;
          end
          if (dump_done !== (byte_idx == DUMP_BYTES))
          begin
            $display("Mismatch time=%0t signal=dump_done expected=%b actual=%b",
                     $time, (byte_idx == DUMP_BYTES), dump_done);
            mismatch_cnt++;
          end
          if (byte_idx == DUMP_BYTES)           // Checksum byte closes the frame
          begin
            active = 1'b0;
            busy_exp = 1'b0;                    // busy drops one edge later
            frame_cnt++;
          end
          else
          begin
            byte_idx++;
            next_due = cyc + PACE_CYCLES;
          end
        end
      end
      else
      begin
        if (dump_done !== 1'b0)
        begin
          $display("dump_done seen without a byte strobe at %0t", $time);
          other_cnt++;
        end
        if (active && cyc == next_due)
        begin
          $display("Byte %0d missing at edge %0d (time %0t)", byte_idx, cyc, $time);
          other_cnt++;
        end
      end
      if (dump_req && !busy && !active)         // Request taken only while idle
      begin
        active = 1'b1;
        latch_due = 1'b1;
        byte_idx = 0;
        next_due = cyc + PACE_CYCLES + 2;       // Strobe starts PACE+1 edges on, seen one later
      end
    end
  end

endmodule

// File: test/debug_dump_tb.sv
`timescale 1ns/100ps

module debug_dump_tb
  import debug_dump_pkg::*;
();

  localparam int PACE_CYCLES = 4;
  localparam int NUM_ROWS    = 5;
  localparam int DONE_LIMIT  = FRAME_BYTES * (PACE_CYCLES + 1) + 20; // Cycles per frame, max
  localparam int IDLE_LIMIT  = 10;

  typedef struct packed {
    logic [1:0]  fill;                          // 0 incrementing, 1 constant, 2 random
    logic [31:0] base;                          // Start value or constant
    logic [18:0] ctrl;                          // ID, EX, MEM bits in port order
    logic        extra;                         // Pulse dump_req while busy
  } row_t;

  logic          clk;
  logic          rst;
  logic          dump_req;
  logic [1023:0] reg_file;
  logic          branch_id, mem_read_id, mem_write_id, alu_src_id, reg_write_id;
  logic [1:0]    reg_dst_id, mem_to_reg_id, alu_op_id;
  logic          mem_read_ex, mem_write_ex, reg_write_ex;
  logic [1:0]    mem_to_reg_ex;
  logic          reg_write_mem;
  logic [1:0]    mem_to_reg_mem;
  logic [7:0]    byte_data;
  logic          byte_valid;
  logic          busy;
  logic          dump_done;
  int            mismatch_cnt, other_cnt, frame_cnt, strobe_cnt;
  int            tb_errs;                       // Timeouts and count faults
  integer        seed = 32'h3502_1447;
  row_t          rows [0:NUM_ROWS-1];

  debug_dump_top #(.PACE_CYCLES(PACE_CYCLES)) UUT (.*);

  debug_dump_checker #(.PACE_CYCLES(PACE_CYCLES)) chk (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;                     // 100 ns period
  end

  task automatic tick();
    @(posedge clk);
    #10;                                        // Drive point after the edge
  endtask

  task automatic drive_ctrl(input logic [18:0] c);
    {branch_id, mem_read_id, mem_write_id, alu_src_id, reg_write_id, reg_dst_id,
     mem_to_reg_id, alu_op_id, mem_read_ex, mem_write_ex, reg_write_ex, mem_to_reg_ex,
     reg_write_mem, mem_to_reg_mem} = c;
  endtask

  task automatic fill_regs(input logic [1:0] mode, input logic [31:0] base);
    for (int r = 0; r < 32; r++)
    begin
      case (mode)
        2'd0:    reg_file[32*r +: 32] = base + r * 32'h0101_0101; // Every byte steps
        2'd1:    reg_file[32*r +: 32] = base;
        default: reg_file[32*r +: 32] = $random(seed);
      endcase
    end
  endtask

  task automatic pulse_req();
    dump_req = 1'b1;
    tick();
    dump_req = 1'b0;
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (dump_done !== 1'b1 && n < DONE_LIMIT)
    begin
      tick();
      n++;
    end
    if (dump_done !== 1'b1)
    begin
      $display("Timeout: no dump_done within %0d cycles at %0t", DONE_LIMIT, $time);
      tb_errs++;
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy !== 1'b0 && n < IDLE_LIMIT)
    begin
      tick();
      n++;
    end
    if (busy !== 1'b0)
    begin
      $display("Timeout: busy still high %0d cycles after the frame at %0t", IDLE_LIMIT, $time);
      tb_errs++;
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial
  begin
    rst = 1'b1;
    dump_req = 1'b0;
    reg_file = '0;
    drive_ctrl('0);
    tb_errs = 0;
    rows[0] = {2'd0, 32'h0000_0000, 19'h00000, 1'b0};
    rows[1] = {2'd1, 32'hA5C3_0F96, 19'h7FFFF, 1'b1};
    rows[2] = {2'd2, 32'h0000_0000, 19'h55555, 1'b0};
    rows[3] = {2'd0, 32'hF0E0_D0C0, 19'h2AAAA, 1'b1};
    rows[4] = {2'd2, 32'h0000_0000, 19'h1C3A5, 1'b1};
    repeat (8) @(posedge clk);
    #10;
    rst = 1'b0;
    repeat (IDLE_LIMIT) tick();                 // Quiet outputs before any request
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      fill_regs(rows[i].fill, rows[i].base);
      drive_ctrl(rows[i].ctrl);
      pulse_req();
      repeat (3) tick();                        // Snapshot already taken
      fill_regs(2'd2, 32'h0);                   // Scramble inputs mid-frame
      drive_ctrl(~rows[i].ctrl);
      if (rows[i].extra)
      begin
        repeat (20) tick();
        pulse_req();                            // Ignored, frame in progress
      end
      wait_done();
      if (rows[i].extra)
        pulse_req();                            // Hits the done cycle, busy still high
      wait_idle();
      repeat (2) tick();
    end
    repeat (FRAME_BYTES) tick();                // Room for any stray frame
    if (frame_cnt != NUM_ROWS || strobe_cnt != NUM_ROWS * FRAME_BYTES)
    begin
      $display("Expected %0d frames and %0d strobes, saw %0d frames and %0d strobes",
               NUM_ROWS, NUM_ROWS * FRAME_BYTES, frame_cnt, strobe_cnt);
      tb_errs++;
    end
    $display("Summary: %0d frames, %0d strobes, %0d mismatches, %0d other errors",
             frame_cnt, strobe_cnt, mismatch_cnt, other_cnt + tb_errs);
    if (mismatch_cnt + other_cnt + tb_errs == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: debug_dump_top.f
source/debug_dump_pkg.sv
source/snapshot_buffer.sv
source/byte_pacer.sv
source/frame_checksum.sv
source/dump_ctrl.sv
source/debug_dump_top.sv
test/debug_dump_checker.sv
test/debug_dump_tb.sv

// File: Bender.yml
package:
  name: debug_dump

sources:
  - source/debug_dump_pkg.sv
  - source/snapshot_buffer.sv
  - source/byte_pacer.sv
  - source/frame_checksum.sv
  - source/dump_ctrl.sv
  - source/debug_dump_top.sv
  - target: test
    files:
      - test/debug_dump_checker.sv
      - test/debug_dump_tb.sv
